//--- hdl/trace_fifo.sv
`timescale 1ns/1ps

`include "trace_settings.svh"

module trace_fifo import trace_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wr,
  input  logic [31:0]               wr_pc,
  input  logic [31:0]               wr_instr,
  input  logic [`TRACE_CYCLE_W-1:0] wr_cycle,
  input  trace_mnem_e               wr_mnem,
  input  logic [31:0]               wr_addr,
  input  logic                      pop,
  output logic                      valid,
  output logic [31:0]               rd_pc,
  output logic [31:0]               rd_instr,
  output logic [`TRACE_CYCLE_W-1:0] rd_cycle,
  output trace_mnem_e               rd_mnem,
  output logic [31:0]               rd_addr,
  output logic                      overflow
);

  localparam int DEPTH = `TRACE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [31:0]               mem_pc    [DEPTH];
  logic [31:0]               mem_instr [DEPTH];
  logic [`TRACE_CYCLE_W-1:0] mem_cycle [DEPTH];
  trace_mnem_e               mem_mnem  [DEPTH];
  logic [31:0]               mem_addr  [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [PTR_W:0]            fill;
  logic                      full;
  logic                      push;
  logic                      pull;

  // wrap without assuming a power-of-two depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full  = (fill == (PTR_W + 1)'(DEPTH));
  assign valid = (fill != '0);
  assign pull  = pop && valid;
  // a pop at the same edge frees the slot even when full
  assign push  = wr && (!full || pull);

  //////////////////////////////////////////////////////////////////////
  // pointers, fill level, sticky drop flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pull)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push, pull})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      if (wr && !push)
        overflow <= 1'b1;
    end
  end

  // record storage
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem_pc[wr_ptr]    <= wr_pc;
      mem_instr[wr_ptr] <= wr_instr;
      mem_cycle[wr_ptr] <= wr_cycle;
      mem_mnem[wr_ptr]  <= wr_mnem;
      mem_addr[wr_ptr]  <= wr_addr;
    end
  end

  // head record
  assign rd_pc    = mem_pc[rd_ptr];
  assign rd_instr = mem_instr[rd_ptr];
  assign rd_cycle = mem_cycle[rd_ptr];
  assign rd_mnem  = mem_mnem[rd_ptr];
  assign rd_addr  = mem_addr[rd_ptr];

endmodule

//--- hdl/trace_imm_gen.sv
`timescale 1ns/1ps

module trace_imm_gen import trace_pkg::*;
(
  input  trace_instr_u instr,
  output logic [31:0]  imm_i,
  output logic [31:0]  imm_s,
  output logic [31:0]  imm_sb,
  output logic [31:0]  imm_u,
  output logic [31:0]  imm_uj
);

  logic sign;

  // bit 31 is the sign in every format
  assign sign = instr.i.imm12[11];

  // I type, 12 bits straight from the top
  assign imm_i = {{20{sign}}, instr.i.imm12};

  // S type, glued back from the two halves
  assign imm_s = {{20{sign}}, instr.s.imm_hi, instr.s.imm_lo};

  // SB type, bit 11 lives in the low half, bit 0 is implicit
  assign imm_sb = {
    {19{sign}},
    instr.s.imm_hi[6],
    instr.s.imm_lo[0],
    instr.s.imm_hi[5:0],
    instr.s.imm_lo[4:1],
    1'b0
  };

  // U type, upper 20 bits
  assign imm_u = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'b0};

  // UJ type
  // instr[19:12] is rs1/funct3, instr[20] is imm12[0]
  assign imm_uj = {
    {12{sign}},
    instr.i.rs1,
    instr.i.funct3,
    instr.i.imm12[0],
    instr.i.imm12[10:1],
    1'b0
  };

endmodule

//--- hdl/trace_pkg.sv
package trace_pkg;

  //////////////////////////////////////////////////////////////////////
  // instruction word views
  //////////////////////////////////////////////////////////////////////

  // register format, rs3 sits in funct7[6:2]
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } trace_r_view_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } trace_i_view_t;

  // store format, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } trace_s_view_t;

  typedef union packed {
    trace_r_view_t r;
    trace_i_view_t i;
    trace_s_view_t s;
  } trace_instr_u;

  //////////////////////////////////////////////////////////////////////
  // mnemonic codes
  //////////////////////////////////////////////////////////////////////

  // each load/store size has four variants in a fixed order:
  // plain, post-increment, reg-reg, reg-reg post-increment
  typedef enum logic [7:0] {
    MN_INVALID, MN_NOP,
    MN_LUI, MN_AUIPC, MN_JAL, MN_JALR,
    MN_BEQ, MN_BNE, MN_BLT, MN_BGE, MN_BLTU, MN_BGEU,
    MN_ADDI, MN_SLTI, MN_SLTIU, MN_XORI, MN_ORI, MN_ANDI, MN_SLLI, MN_SRLI, MN_SRAI,
    MN_ADD, MN_SUB, MN_SLL, MN_SLT, MN_SLTU, MN_XOR, MN_SRL, MN_SRA, MN_OR, MN_AND,
    MN_LB, MN_LB_POST, MN_LB_RR, MN_LB_RR_POST,
    MN_LH, MN_LH_POST, MN_LH_RR, MN_LH_RR_POST,
    MN_LW, MN_LW_POST, MN_LW_RR, MN_LW_RR_POST,
    MN_LBU, MN_LBU_POST, MN_LBU_RR, MN_LBU_RR_POST,
    MN_LHU, MN_LHU_POST, MN_LHU_RR, MN_LHU_RR_POST,
    MN_SB, MN_SB_POST, MN_SB_RR, MN_SB_RR_POST,
    MN_SH, MN_SH_POST, MN_SH_RR, MN_SH_RR_POST,
    MN_SW, MN_SW_POST, MN_SW_RR, MN_SW_RR_POST,
    MN_CSRRW, MN_CSRRS, MN_CSRRC, MN_CSRRWI, MN_CSRRSI, MN_CSRRCI,
    MN_ECALL, MN_EBREAK, MN_ERET, MN_WFI
  } trace_mnem_e;

endpackage

//--- hdl/trace_record_gen.sv
`timescale 1ns/1ps

`include "trace_settings.svh"

module trace_record_gen import trace_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [31:0]               pc,
  input  logic [31:0]               instr,
  input  logic [31:0]               rs1_value,
  input  logic [31:0]               rs2_value,
  input  logic [31:0]               rs3_value,
  input  logic                      id_valid,
  input  logic                      is_decoding,
  input  logic                      pipe_flush,
  output logic                      rec_wr,
  output logic [31:0]               rec_pc,
  output logic [31:0]               rec_instr,
  output logic [`TRACE_CYCLE_W-1:0] rec_cycle,
  output trace_mnem_e               rec_mnem,
  output logic [31:0]               rec_addr
);

  trace_instr_u              instr_u;
  logic [31:0]               imm_i;
  logic [31:0]               imm_s;
  logic [31:0]               imm_sb;
  logic [31:0]               imm_u;
  logic [31:0]               imm_uj;
  logic [`TRACE_CYCLE_W-1:0] cycle_cnt;
  logic                      is_post;
  logic                      ld_rr;
  logic [2:0]                ld_size;
  logic                      ld_ok;
  trace_mnem_e               ld_base;
  logic                      st_rr;
  logic                      st_ok;
  trace_mnem_e               st_base;

  assign instr_u = instr;

  trace_imm_gen imm_gen_i
  (
    .instr  (instr_u),
    .imm_i  (imm_i),
    .imm_s  (imm_s),
    .imm_sb (imm_sb),
    .imm_u  (imm_u),
    .imm_uj (imm_uj)
  );

  //////////////////////////////////////////////////////////////////////
  // cycle stamp and capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cycle_cnt <= '0;
    else
      cycle_cnt <= cycle_cnt + 1'b1;
  end

  // written by the FIFO at the capture edge, so the stamp is pre-edge
  assign rec_wr    = (id_valid && is_decoding) || pipe_flush;
  assign rec_pc    = pc;
  assign rec_instr = instr;
  assign rec_cycle = cycle_cnt;

  //////////////////////////////////////////////////////////////////////
  // load/store size decode
  //////////////////////////////////////////////////////////////////////

  assign is_post = (instr_u.r.opcode == `OPC_LOAD_POST) ||
                   (instr_u.r.opcode == `OPC_STORE_POST);

  // reg-reg load: funct3 == 7, real size in instr[30:28]
  always_comb
  begin
    ld_rr   = (instr_u.i.funct3 == 3'b111);
    ld_size = ld_rr ? instr_u.i.imm12[10:8] : instr_u.i.funct3;
    ld_ok   = 1'b1;
    case (ld_size)
      3'b000:  ld_base = MN_LB;
      3'b001:  ld_base = MN_LH;
      3'b010:  ld_base = MN_LW;
      3'b100:  ld_base = MN_LBU;
      3'b101:  ld_base = MN_LHU;
      default:
      begin
        ld_base = MN_INVALID;
        ld_ok   = 1'b0;
      end
    endcase
  end

  // reg-reg store flagged by bit 14
  always_comb
  begin
    st_rr = instr_u.s.funct3[2];
    st_ok = 1'b1;
    case (instr_u.s.funct3[1:0])
      2'b00:   st_base = MN_SB;
      2'b01:   st_base = MN_SH;
      2'b10:   st_base = MN_SW;
      default:
      begin
        st_base = MN_INVALID;
        st_ok   = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // mnemonic and computed address
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rec_mnem = MN_INVALID;
    rec_addr = '0;
    case (instr_u.r.opcode)
      `OPC_LUI:
      begin
        rec_mnem = MN_LUI;
        rec_addr = imm_u;
      end
      `OPC_AUIPC:
      begin
        rec_mnem = MN_AUIPC;
        rec_addr = pc + imm_u;
      end
      `OPC_JAL:
      begin
        rec_mnem = MN_JAL;
        rec_addr = pc + imm_uj;
      end
      `OPC_JALR:
      begin
        if (instr_u.i.funct3 == 3'b000)
        begin
          rec_mnem = MN_JALR;
          rec_addr = rs1_value + imm_i;
        end
      end
      `OPC_BRANCH:
      begin
        case (instr_u.s.funct3)
          3'b000:  rec_mnem = MN_BEQ;
          3'b001:  rec_mnem = MN_BNE;
          3'b100:  rec_mnem = MN_BLT;
          3'b101:  rec_mnem = MN_BGE;
          3'b110:  rec_mnem = MN_BLTU;
          3'b111:  rec_mnem = MN_BGEU;
          default: rec_mnem = MN_INVALID;
        endcase
        if (rec_mnem != MN_INVALID)
          rec_addr = pc + imm_sb;
      end
      `OPC_OPIMM:
      begin
        // addi x0, x0, 0 is the canonical nop
        if (instr == 32'h0000_0013)
          rec_mnem = MN_NOP;
        else
        begin
          case (instr_u.i.funct3)
            3'b000:  rec_mnem = MN_ADDI;
            3'b010:  rec_mnem = MN_SLTI;
            3'b011:  rec_mnem = MN_SLTIU;
            3'b100:  rec_mnem = MN_XORI;
            3'b110:  rec_mnem = MN_ORI;
            3'b111:  rec_mnem = MN_ANDI;
            3'b001:  rec_mnem = (instr_u.r.funct7 == 7'h00) ? MN_SLLI : MN_INVALID;
            default:
            begin
              if (instr_u.r.funct7 == 7'h00)
                rec_mnem = MN_SRLI;
              else if (instr_u.r.funct7 == 7'h20)
                rec_mnem = MN_SRAI;
            end
          endcase
        end
      end
      `OPC_OP:
      begin
        // mul and PULP extension ops fall out as invalid
        case ({instr_u.r.funct7, instr_u.r.funct3})
          {7'h00, 3'b000}: rec_mnem = MN_ADD;
          {7'h20, 3'b000}: rec_mnem = MN_SUB;
          {7'h00, 3'b001}: rec_mnem = MN_SLL;
          {7'h00, 3'b010}: rec_mnem = MN_SLT;
          {7'h00, 3'b011}: rec_mnem = MN_SLTU;
          {7'h00, 3'b100}: rec_mnem = MN_XOR;
          {7'h00, 3'b101}: rec_mnem = MN_SRL;
          {7'h20, 3'b101}: rec_mnem = MN_SRA;
          {7'h00, 3'b110}: rec_mnem = MN_OR;
          {7'h00, 3'b111}: rec_mnem = MN_AND;
          default:         rec_mnem = MN_INVALID;
        endcase
      end
      `OPC_LOAD, `OPC_LOAD_POST:
      begin
        if (ld_ok)
        begin
          rec_mnem = trace_mnem_e'(ld_base + {6'd0, ld_rr, is_post});
          if (is_post)
            rec_addr = rs1_value;
          else if (ld_rr)
            rec_addr = rs1_value + rs2_value;
          else
            rec_addr = rs1_value + imm_i;
        end
      end
      `OPC_STORE, `OPC_STORE_POST:
      begin
        if (st_ok)
        begin
          rec_mnem = trace_mnem_e'(st_base + {6'd0, st_rr, is_post});
          if (is_post)
            rec_addr = rs1_value;
          else if (st_rr)
            rec_addr = rs1_value + rs3_value;
          else
            rec_addr = rs1_value + imm_s;
        end
      end
      `OPC_SYSTEM:
      begin
        case (instr_u.i.funct3)
          3'b001: rec_mnem = MN_CSRRW;
          3'b010: rec_mnem = MN_CSRRS;
          3'b011: rec_mnem = MN_CSRRC;
          3'b101: rec_mnem = MN_CSRRWI;
          3'b110: rec_mnem = MN_CSRRSI;
          3'b111: rec_mnem = MN_CSRRCI;
          3'b000:
          begin
            // privileged ops need an exact match
            case (instr)
              32'h0000_0073: rec_mnem = MN_ECALL;
              32'h0010_0073: rec_mnem = MN_EBREAK;
              32'h1000_0073: rec_mnem = MN_ERET;
              32'h1020_0073: rec_mnem = MN_WFI;
              default:       rec_mnem = MN_INVALID;
            endcase
          end
          default: rec_mnem = MN_INVALID;
        endcase
      end
      default:
      begin
        rec_mnem = MN_INVALID;
      end
    endcase
  end

endmodule

//--- hdl/trace_settings.svh
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// record queue
//////////////////////////////////////////////////////////////////////

// records held before captures start to drop
`define TRACE_FIFO_DEPTH 8

// free-running cycle stamp
`define TRACE_CYCLE_W 32

//////////////////////////////////////////////////////////////////////
// major opcodes, including the PULP post-increment load/store
//////////////////////////////////////////////////////////////////////

`define OPC_LOAD       7'h03
`define OPC_LOAD_POST  7'h0b
`define OPC_STORE      7'h23
`define OPC_STORE_POST 7'h2b
`define OPC_OP         7'h33
`define OPC_OPIMM      7'h13
`define OPC_BRANCH     7'h63
`define OPC_JAL        7'h6f
`define OPC_JALR       7'h67
`define OPC_LUI        7'h37
`define OPC_AUIPC      7'h17
`define OPC_SYSTEM     7'h73

`endif

//--- hdl/trace_unit.sv
`timescale 1ns/1ps

`include "trace_settings.svh"

module trace_unit import trace_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,

  // decode stage of the core
  input  logic [31:0]               pc,
  input  logic [31:0]               instr,
  input  logic [31:0]               rs1_value,
  input  logic [31:0]               rs2_value,
  input  logic [31:0]               rs3_value,
  input  logic                      id_valid,
  input  logic                      is_decoding,
  input  logic                      pipe_flush,

  // record readout
  output logic                      trace_valid,
  output logic [31:0]               trace_pc,
  output logic [31:0]               trace_instr,
  output logic [`TRACE_CYCLE_W-1:0] trace_cycle,
  output trace_mnem_e               trace_mnem,
  output logic [31:0]               trace_addr,
  output logic                      trace_overflow,
  input  logic                      trace_pop
);

  logic                      rec_wr;
  logic [31:0]               rec_pc;
  logic [31:0]               rec_instr;
  logic [`TRACE_CYCLE_W-1:0] rec_cycle;
  trace_mnem_e               rec_mnem;
  logic [31:0]               rec_addr;

  trace_record_gen record_gen_i
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc          (pc),
    .instr       (instr),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .rs3_value   (rs3_value),
    .id_valid    (id_valid),
    .is_decoding (is_decoding),
    .pipe_flush  (pipe_flush),
    .rec_wr      (rec_wr),
    .rec_pc      (rec_pc),
    .rec_instr   (rec_instr),
    .rec_cycle   (rec_cycle),
    .rec_mnem    (rec_mnem),
    .rec_addr    (rec_addr)
  );

  // depth of TRACE_FIFO_DEPTH records
  trace_fifo fifo_i
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (rec_wr),
    .wr_pc    (rec_pc),
    .wr_instr (rec_instr),
    .wr_cycle (rec_cycle),
    .wr_mnem  (rec_mnem),
    .wr_addr  (rec_addr),
    .pop      (trace_pop),
    .valid    (trace_valid),
    .rd_pc    (trace_pc),
    .rd_instr (trace_instr),
    .rd_cycle (trace_cycle),
    .rd_mnem  (trace_mnem),
    .rd_addr  (trace_addr),
    .overflow (trace_overflow)
  );

endmodule

//--- project.f
+incdir+hdl
hdl/trace_pkg.sv
hdl/trace_imm_gen.sv
hdl/trace_record_gen.sv
hdl/trace_fifo.sv
hdl/trace_unit.sv
verif/trace_unit_chk.sv
verif/trace_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the trace unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f project.f \
  --top-module trace_unit_tb \
  --Mdir obj_dir \
  -o trace_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/trace_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verif/trace_unit_chk.sv
`timescale 1ns/1ps

module trace_unit_chk
(
  input logic clk,
  input logic rst_n,
  input logic id_valid,
  input logic is_decoding,
  input logic pipe_flush,
  input logic trace_valid,
  input logic trace_overflow
);

  logic capture;

  assign capture = (id_valid && is_decoding) || pipe_flush;

  //////////////////////////////////////////////////////////////////////
  // reset and readout properties
  //////////////////////////////////////////////////////////////////////

  // outputs held low while reset is active
  reset_quiet: assert property (
    @(posedge clk) !rst_n |-> (!trace_valid && !trace_overflow)
  )
  else
    $error("trace_valid or trace_overflow high during reset");

  // drop flag is sticky until reset
  overflow_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) trace_overflow |=> trace_overflow
  )
  else
    $error("trace_overflow fell without a reset");

  // a captured record is always readable on the next cycle
  valid_after_capture: assert property (
    @(posedge clk) disable iff (!rst_n) capture |=> trace_valid
  )
  else
    $error("trace_valid low in the cycle after a capture");

endmodule

//--- verif/trace_unit_tb.sv
`timescale 1ns/1ps

`include "trace_settings.svh"

module trace_unit_tb import trace_pkg::*;
();

  localparam int DEPTH         = `TRACE_FIFO_DEPTH;
  localparam int VALID_TIMEOUT = 20;
  localparam logic [31:0] RS1 = 32'h0000_1000;
  localparam logic [31:0] RS2 = 32'h0000_0020;
  localparam logic [31:0] RS3 = 32'h0000_0300;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] rs3;
    trace_mnem_e mnem;
    logic [31:0] addr;
  } entry_t;

  logic                      clk;
  logic                      rst_n;
  logic [31:0]               pc;
  logic [31:0]               instr;
  logic [31:0]               rs1_value;
  logic [31:0]               rs2_value;
  logic [31:0]               rs3_value;
  logic                      id_valid;
  logic                      is_decoding;
  logic                      pipe_flush;
  logic                      trace_pop;
  logic                      trace_valid;
  logic [31:0]               trace_pc;
  logic [31:0]               trace_instr;
  logic [`TRACE_CYCLE_W-1:0] trace_cycle;
  trace_mnem_e               trace_mnem;
  logic [31:0]               trace_addr;
  logic                      trace_overflow;

  entry_t                    stim_q [$];
  int                        cap_q [$];
  int                        edges;
  logic [15:0]               lfsr_state;
  logic                      have_prev;
  int                        prev_edge;
  logic [`TRACE_CYCLE_W-1:0] prev_stamp;

  trace_unit dut_i
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc             (pc),
    .instr          (instr),
    .rs1_value      (rs1_value),
    .rs2_value      (rs2_value),
    .rs3_value      (rs3_value),
    .id_valid       (id_valid),
    .is_decoding    (is_decoding),
    .pipe_flush     (pipe_flush),
    .trace_valid    (trace_valid),
    .trace_pc       (trace_pc),
    .trace_instr    (trace_instr),
    .trace_cycle    (trace_cycle),
    .trace_mnem     (trace_mnem),
    .trace_addr     (trace_addr),
    .trace_overflow (trace_overflow),
    .trace_pop      (trace_pop)
  );

  bind trace_unit trace_unit_chk chk_i
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_valid       (id_valid),
    .is_decoding    (is_decoding),
    .pipe_flush     (pipe_flush),
    .trace_valid    (trace_valid),
    .trace_overflow (trace_overflow)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // one full cycle, ending on the falling edge
  task automatic step();
    @(negedge clk);
    edges++;
  endtask

  task automatic wait_valid(input string what);
    int n;
    n = 0;
    while (!trace_valid && n < VALID_TIMEOUT)
    begin
      step();
      n++;
    end
    if (!trace_valid)
    begin
      $display("timeout: no trace record became valid during %s", what);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  endtask

  task automatic add_entry(input logic [31:0] e_pc, input logic [31:0] e_instr,
                           input logic [31:0] e_rs1, input logic [31:0] e_rs2,
                           input logic [31:0] e_rs3, input trace_mnem_e e_mnem,
                           input logic [31:0] e_addr);
    stim_q.push_back('{e_pc, e_instr, e_rs1, e_rs2, e_rs3, e_mnem, e_addr});
  endtask

  // encodings and addresses worked out by hand from the ISA
  task automatic build_table();
    add_entry(32'h0000_0100, 32'h1234_50b7, RS1, RS2, RS3, MN_LUI, 32'h1234_5000);
    add_entry(32'h0000_0200, 32'h0000_1097, RS1, RS2, RS3, MN_AUIPC, 32'h0000_1200);
    add_entry(32'h0000_0300, 32'h0100_00ef, RS1, RS2, RS3, MN_JAL, 32'h0000_0310);
    add_entry(32'h0000_0400, 32'hff9f_f06f, RS1, RS2, RS3, MN_JAL, 32'h0000_03f8);
    add_entry(32'h0000_0500, 32'h0081_00e7, RS1, RS2, RS3, MN_JALR, 32'h0000_1008);
    add_entry(32'h0000_0600, 32'h0020_8463, RS1, RS2, RS3, MN_BEQ, 32'h0000_0608);
    add_entry(32'h0000_0700, 32'hfe20_9ee3, RS1, RS2, RS3, MN_BNE, 32'h0000_06fc);
    add_entry(32'h0000_0800, 32'h0020_f463, RS1, RS2, RS3, MN_BGEU, 32'h0000_0808);
    add_entry(32'h0000_0900, 32'h0020_a463, RS1, RS2, RS3, MN_INVALID, 32'h0);
    add_entry(32'h0000_0a00, 32'h0000_0013, RS1, RS2, RS3, MN_NOP, 32'h0);
    add_entry(32'h0000_0a04, 32'h0051_0093, RS1, RS2, RS3, MN_ADDI, 32'h0);
    add_entry(32'h0000_0a08, 32'h4031_5093, RS1, RS2, RS3, MN_SRAI, 32'h0);
    add_entry(32'h0000_0a0c, 32'h4020_81b3, RS1, RS2, RS3, MN_SUB, 32'h0);
    add_entry(32'h0000_0a10, 32'h0020_f1b3, RS1, RS2, RS3, MN_AND, 32'h0);
    // mul is outside the traced set
    add_entry(32'h0000_0a14, 32'h0220_81b3, RS1, RS2, RS3, MN_INVALID, 32'h0);
    add_entry(32'h0000_0b00, 32'h00c1_2083, RS1, RS2, RS3, MN_LW, 32'h0000_100c);
    add_entry(32'h0000_0b04, 32'hffc1_0083, RS1, RS2, RS3, MN_LB, 32'h0000_0ffc);
    add_entry(32'h0000_0b08, 32'h0041_508b, RS1, RS2, RS3, MN_LHU_POST, 32'h0000_1000);
    add_entry(32'h0000_0b0c, 32'h2031_7083, RS1, RS2, RS3, MN_LW_RR, 32'h0000_1020);
    add_entry(32'h0000_0b10, 32'h4031_708b, RS1, RS2, RS3, MN_LBU_RR_POST, 32'h0000_1000);
    add_entry(32'h0000_0b14, 32'h00c1_3083, RS1, RS2, RS3, MN_INVALID, 32'h0);
    add_entry(32'h0000_0b18, 32'h6031_7083, RS1, RS2, RS3, MN_INVALID, 32'h0);
    add_entry(32'h0000_0c00, 32'h0031_2423, RS1, RS2, RS3, MN_SW, 32'h0000_1008);
    add_entry(32'h0000_0c04, 32'hfe31_0823, RS1, RS2, RS3, MN_SB, 32'h0000_0ff0);
    add_entry(32'h0000_0c08, 32'h0031_112b, RS1, RS2, RS3, MN_SH_POST, 32'h0000_1000);
    add_entry(32'h0000_0c0c, 32'h0031_6023, RS1, RS2, RS3, MN_SW_RR, 32'h0000_1300);
    add_entry(32'h0000_0c10, 32'h0031_402b, RS1, RS2, RS3, MN_SB_RR_POST, 32'h0000_1000);
    add_entry(32'h0000_0c14, 32'h0031_3023, RS1, RS2, RS3, MN_INVALID, 32'h0);
    add_entry(32'h0000_0d00, 32'h3001_10f3, RS1, RS2, RS3, MN_CSRRW, 32'h0);
    add_entry(32'h0000_0d04, 32'h3001_70f3, RS1, RS2, RS3, MN_CSRRCI, 32'h0);
    add_entry(32'h0000_0d08, 32'h0000_0073, RS1, RS2, RS3, MN_ECALL, 32'h0);
    add_entry(32'h0000_0d0c, 32'h0010_0073, RS1, RS2, RS3, MN_EBREAK, 32'h0);
    add_entry(32'h0000_0d10, 32'h1000_0073, RS1, RS2, RS3, MN_ERET, 32'h0);
    add_entry(32'h0000_0d14, 32'h1020_0073, RS1, RS2, RS3, MN_WFI, 32'h0);
    // fence decodes as invalid
    add_entry(32'h0000_0d18, 32'h0000_000f, RS1, RS2, RS3, MN_INVALID, 32'h0);
  endtask

  // one-cycle strobe, remembers which edge sampled it
  task automatic capture_entry(input int idx, input logic from_flush);
    entry_t e;
    e = stim_q[idx];
    pc          = e.pc;
    instr       = e.instr;
    rs1_value   = e.rs1;
    rs2_value   = e.rs2;
    rs3_value   = e.rs3;
    id_valid    = !from_flush;
    is_decoding = !from_flush;
    pipe_flush  = from_flush;
    cap_q.push_back(edges + 1);
    step();
    id_valid    = 1'b0;
    is_decoding = 1'b0;
    pipe_flush  = 1'b0;
  endtask

  task automatic check_head(input int idx);
    entry_t e;
    int     cap_edge;
    e = stim_q[idx];
    cap_edge = cap_q.pop_front();
    check_value($sformatf("entry %0d pc", idx), e.pc, trace_pc);
    check_value($sformatf("entry %0d instr", idx), e.instr, trace_instr);
    check_value($sformatf("entry %0d mnem", idx), 32'(e.mnem), 32'(trace_mnem));
    check_value($sformatf("entry %0d addr", idx), e.addr, trace_addr);
    // stamp distance equals counted rising edges
    if (have_prev)
      check_value($sformatf("entry %0d cycle delta", idx), 32'(cap_edge - prev_edge),
                  32'(trace_cycle - prev_stamp));
    have_prev  = 1'b1;
    prev_edge  = cap_edge;
    prev_stamp = trace_cycle;
  endtask

  task automatic pop_record();
    trace_pop = 1'b1;
    step();
    trace_pop = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [1:0] gap;
    logic       from_flush;
    int         n_flush;
    int         n_decode;
    rst_n       = 1'b0;
    pc          = '0;
    instr       = '0;
    rs1_value   = '0;
    rs2_value   = '0;
    rs3_value   = '0;
    id_valid    = 1'b0;
    is_decoding = 1'b0;
    pipe_flush  = 1'b0;
    trace_pop   = 1'b0;
    edges       = 0;
    have_prev   = 1'b0;
    prev_edge   = 0;
    prev_stamp  = '0;
    n_flush     = 0;
    n_decode    = 0;
    lfsr_state  = 16'd62;
    build_table();
    repeat (10) step();
    rst_n = 1'b1;
    step();
    check_value("reset trace_valid", 32'd0, 32'(trace_valid));
    check_value("reset trace_overflow", 32'd0, 32'(trace_overflow));

    // decode, addresses, both capture sources, stamps
    for (int i = 0; i < stim_q.size(); i++)
    begin
      gap        = {next_rand_bit(), next_rand_bit()};
      from_flush = next_rand_bit();
      // stalled decode must not be traced
      id_valid = 1'b1;
      repeat (gap) step();
      check_value($sformatf("entry %0d stalled idle", i), 32'd0, 32'(trace_valid));
      if (from_flush)
        n_flush++;
      else
        n_decode++;
      capture_entry(i, from_flush);
      wait_valid($sformatf("capture of entry %0d", i));
      check_head(i);
      pop_record();
      check_value($sformatf("entry %0d valid after pop", i), 32'd0, 32'(trace_valid));
    end
    if (n_flush == 0 || n_decode == 0)
    begin
      $display("capture sources were not both exercised by the random choice");
      $display("TEST FAILED");
      $fatal(1, "capture source coverage");
    end

    // fill past the depth without popping
    for (int i = 0; i < DEPTH + 2; i++)
      capture_entry(i, 1'b0);
    check_value("overflow after filling", 32'd1, 32'(trace_overflow));
    for (int i = 0; i < DEPTH; i++)
    begin
      wait_valid($sformatf("drain of record %0d", i));
      check_head(i);
      pop_record();
    end
    check_value("valid after drain", 32'd0, 32'(trace_valid));
    check_value("overflow after drain", 32'd1, 32'(trace_overflow));

    $display("TEST PASSED");
    $finish;
  end

endmodule
